// ==== rtl/cache_types_pkg.sv ====
package cache_types_pkg;

    // Line geometry, fixed by the 256-bit memory interface
    localparam int OFFSET_BITS = 5;
    localparam int LINE_BYTES  = 2 ** OFFSET_BITS;
    localparam int LINE_BITS   = 8 * LINE_BYTES;

    typedef logic [LINE_BITS-1:0] line_t;

    // Word request from the AXI front end
    typedef struct packed {
        logic [31:0]           addr;
        logic [31:0]           wdata;
        // Byte enables already placed at the word position in the line
        logic [LINE_BYTES-1:0] wmask;
        logic                  write;
    } cpu_req_t;

    // Result returned to the front end
    typedef struct packed {
        logic [31:0] rdata;
        logic        done;
    } cpu_rsp_t;

    // Line request towards main memory
    typedef struct packed {
        logic [31:0] addr;
        line_t       wdata;
        logic        read;
        logic        write;
    } mem_req_t;

endpackage

// ==== rtl/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL,
        RESPOND
    } ctrl_state_t;

    // Data array input source
    typedef enum logic {
        CPU_WDATA,
        MEM_RDATA
    } datamux_sel_t;

    // Memory address source
    typedef enum logic [1:0] {
        REQ_ADDR,
        WAY0_ADDR,
        WAY1_ADDR
    } addrmux_sel_t;

    // Array loads for one way
    typedef struct packed {
        logic load_tag;
        logic set_valid;
        logic load_dirty;
        logic dirty_in;
        logic load_data;
    } way_ctrl_t;

endpackage

// ==== rtl/cache_array.sv ====
`timescale 1ns/10ps

module cache_array #(
    parameter int INDEX_BITS = 3,
    parameter int WIDTH      = 1
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [(WIDTH+7)/8-1:0]   byte_en,
    input  logic [INDEX_BITS-1:0]    index,
    input  logic [WIDTH-1:0]         din,
    output logic [WIDTH-1:0]         dout
);

    localparam int SETS = 2 ** INDEX_BITS;

    logic [WIDTH-1:0] entries [SETS];

    // Read is combinational, the controller sees the set in the same cycle
    assign dout = entries[index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                entries[s] <= '0;
            end
        end else begin
            // Partial top byte shares the last enable bit
            for (int b = 0; b < WIDTH; b++) begin
                if (byte_en[b / 8]) begin
                    entries[index][b] <= din[b];
                end
            end
        end
    end

endmodule

// ==== rtl/cache_datapath.sv ====
`timescale 1ns/10ps

module cache_datapath #(
    parameter int INDEX_BITS = 3
) (
    input  logic                              clk,
    input  logic                              rst,
    input  cache_types_pkg::cpu_req_t         req,
    input  cache_ctrl_pkg::way_ctrl_t [1:0]   way_ctrl,
    input  logic                              load_lru,
    input  logic                              lru_in,
    input  cache_ctrl_pkg::datamux_sel_t      datamux_sel,
    input  cache_ctrl_pkg::addrmux_sel_t      addrmux_sel,
    input  cache_types_pkg::line_t            mem_rdata,
    output logic                              hit,
    output logic                              hit_way,
    output logic                              lru_way,
    output logic                              lru_dirty,
    output logic [31:0]                       rdata,
    output logic [31:0]                       mem_addr,
    output cache_types_pkg::line_t            mem_wdata
);

    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int TAG_BITS  = 32 - INDEX_BITS - OFFSET_BITS;
    localparam int TAG_BYTES = (TAG_BITS + 7) / 8;

    logic [INDEX_BITS-1:0]  set_index;
    logic [TAG_BITS-1:0]    req_tag;
    logic [OFFSET_BITS-3:0] word_sel;

    logic [TAG_BITS-1:0]    tag_out [2];
    logic                   valid_out [2];
    logic                   dirty_out [2];
    line_t                  data_out [2];
    logic [LINE_BYTES-1:0]  data_be [2];
    logic [LINE_BYTES-1:0]  write_mask;
    line_t                  data_in;
    logic                   lru_out;
    logic [1:0]             way_match;

    // Address split
    assign set_index = req.addr[OFFSET_BITS +: INDEX_BITS];
    assign req_tag   = req.addr[31 -: TAG_BITS];
    assign word_sel  = req.addr[OFFSET_BITS-1:2];

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_array #(.INDEX_BITS(INDEX_BITS), .WIDTH(TAG_BITS)) i_tag_array (
            .clk    (clk),
            .rst    (rst),
            .byte_en({TAG_BYTES{way_ctrl[w].load_tag}}),
            .index  (set_index),
            .din    (req_tag),
            .dout   (tag_out[w])
        );

        // Valid only ever gets set, invalidation is not supported
        cache_array #(.INDEX_BITS(INDEX_BITS), .WIDTH(1)) i_valid_array (
            .clk    (clk),
            .rst    (rst),
            .byte_en(way_ctrl[w].set_valid),
            .index  (set_index),
            .din    (1'b1),
            .dout   (valid_out[w])
        );

        cache_array #(.INDEX_BITS(INDEX_BITS), .WIDTH(1)) i_dirty_array (
            .clk    (clk),
            .rst    (rst),
            .byte_en(way_ctrl[w].load_dirty),
            .index  (set_index),
            .din    (way_ctrl[w].dirty_in),
            .dout   (dirty_out[w])
        );

        cache_array #(.INDEX_BITS(INDEX_BITS), .WIDTH(LINE_BITS)) i_data_array (
            .clk    (clk),
            .rst    (rst),
            .byte_en(data_be[w]),
            .index  (set_index),
            .din    (data_in),
            .dout   (data_out[w])
        );
    end

    // LRU bit names the way to evict next
    cache_array #(.INDEX_BITS(INDEX_BITS), .WIDTH(1)) i_lru_array (
        .clk    (clk),
        .rst    (rst),
        .byte_en(load_lru),
        .index  (set_index),
        .din    (lru_in),
        .dout   (lru_out)
    );

    // Tag match
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_match[w] = valid_out[w] && (tag_out[w] == req_tag);
        end
        hit       = |way_match;
        hit_way   = way_match[1];
        lru_way   = lru_out;
        lru_dirty = dirty_out[lru_out];
    end

    // Data-in select and per-way byte enables
    always_comb begin
        case (datamux_sel)
            CPU_WDATA: begin
                // Word copied to every slot, the mask picks the right one
                data_in    = {(LINE_BITS / 32){req.wdata}};
                write_mask = req.wmask;
            end
            MEM_RDATA: begin
                data_in    = mem_rdata;
                write_mask = '1;
            end
            default: begin
                data_in    = '0;
                write_mask = '0;
            end
        endcase
        for (int w = 0; w < 2; w++) begin
            data_be[w] = way_ctrl[w].load_data ? write_mask : '0;
        end
    end

    assign rdata     = data_out[hit_way][word_sel * 32 +: 32];
    assign mem_wdata = data_out[lru_way];

    // Memory line address
    always_comb begin
        case (addrmux_sel)
            REQ_ADDR:  mem_addr = {req.addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            WAY0_ADDR: mem_addr = {tag_out[0], set_index, {OFFSET_BITS{1'b0}}};
            WAY1_ADDR: mem_addr = {tag_out[1], set_index, {OFFSET_BITS{1'b0}}};
            default:   mem_addr = {req.addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        endcase
    end

endmodule

// ==== rtl/cache_control.sv ====
`timescale 1ns/10ps

module cache_control (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_start,
    input  logic                            req_write,
    input  logic                            hit,
    input  logic                            hit_way,
    input  logic                            lru_way,
    input  logic                            lru_dirty,
    input  logic                            mem_resp,
    output cache_ctrl_pkg::way_ctrl_t [1:0] way_ctrl,
    output logic                            load_lru,
    output logic                            lru_in,
    output cache_ctrl_pkg::datamux_sel_t    datamux_sel,
    output cache_ctrl_pkg::addrmux_sel_t    addrmux_sel,
    output logic                            mem_read,
    output logic                            mem_write,
    output logic                            done
);

    import cache_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next  = state;
        way_ctrl    = '0;
        load_lru    = 1'b0;
        lru_in      = 1'b0;
        datamux_sel = CPU_WDATA;
        addrmux_sel = REQ_ADDR;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        done        = 1'b0;

        case (state)
            IDLE: begin
                if (req_start) begin
                    state_next = LOOKUP;
                end
            end

            LOOKUP: begin
                if (hit) begin
                    // Other way becomes the next victim
                    load_lru = 1'b1;
                    lru_in   = ~hit_way;
                    if (req_write) begin
                        way_ctrl[hit_way].load_data  = 1'b1;
                        way_ctrl[hit_way].load_dirty = 1'b1;
                        way_ctrl[hit_way].dirty_in   = 1'b1;
                    end
                    state_next = RESPOND;
                end else if (lru_dirty) begin
                    state_next = WRITEBACK;
                end else begin
                    state_next = FILL;
                end
            end

            WRITEBACK: begin
                // Victim line goes out at its own stored address
                mem_write   = 1'b1;
                addrmux_sel = lru_way ? WAY1_ADDR : WAY0_ADDR;
                if (mem_resp) begin
                    state_next = FILL;
                end
            end

            FILL: begin
                mem_read    = 1'b1;
                datamux_sel = MEM_RDATA;
                if (mem_resp) begin
                    way_ctrl[lru_way].load_data  = 1'b1;
                    way_ctrl[lru_way].load_tag   = 1'b1;
                    way_ctrl[lru_way].set_valid  = 1'b1;
                    way_ctrl[lru_way].load_dirty = 1'b1;
                    way_ctrl[lru_way].dirty_in   = 1'b0;
                    // Retry the lookup, it hits this time
                    state_next = LOOKUP;
                end
            end

            RESPOND: begin
                done       = 1'b1;
                state_next = IDLE;
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

// ==== rtl/axil_cache_port.sv ====
`timescale 1ns/10ps

module axil_cache_port (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    output logic                      bvalid,
    input  logic                      bready,
    output logic [1:0]                bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic [31:0]               araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    input  logic                      done,
    input  logic [31:0]               rdata_in,
    output cache_types_pkg::cpu_req_t req,
    output logic                      req_start
);

    import cache_types_pkg::*;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        PORT_INIT,
        PORT_IDLE,
        PORT_BUSY,
        PORT_RESP
    } port_state_t;

    port_state_t           state;
    logic                  idle;
    logic                  write_accept;
    logic                  read_accept;
    logic [LINE_BYTES-1:0] strb_line;

    assign idle = (state == PORT_IDLE);

    // AW and W only complete together, a write wins over a read
    assign awready      = idle && wvalid;
    assign wready       = idle && awvalid;
    assign arready      = idle && !(awvalid && wvalid);
    assign write_accept = idle && awvalid && wvalid;
    assign read_accept  = arready && arvalid;
    assign req_start    = write_accept || read_accept;

    assign bvalid = (state == PORT_RESP) && req.write;
    assign rvalid = (state == PORT_RESP) && !req.write;
    assign bresp  = RESP_OKAY;
    assign rresp  = RESP_OKAY;

    assign strb_line = {{(LINE_BYTES - 4){1'b0}}, wstrb};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= PORT_INIT;
        end else begin
            case (state)
                PORT_INIT: state <= PORT_IDLE;
                PORT_IDLE: begin
                    if (req_start) begin
                        state <= PORT_BUSY;
                    end
                end
                PORT_BUSY: begin
                    if (done) begin
                        state <= PORT_RESP;
                    end
                end
                PORT_RESP: begin
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        state <= PORT_IDLE;
                    end
                end
                default: state <= PORT_IDLE;
            endcase
        end
    end

    // Request and read word registers
    always_ff @(posedge clk) begin
        if (write_accept) begin
            req.addr  <= awaddr;
            req.wdata <= wdata;
            // Strobes moved to the word slot, the datapath replicates the word itself
            req.wmask <= strb_line << {awaddr[OFFSET_BITS-1:2], 2'b00};
            req.write <= 1'b1;
        end else if (read_accept) begin
            req.addr  <= araddr;
            req.wdata <= '0;
            req.wmask <= '0;
            req.write <= 1'b0;
        end
        if (done) begin
            rdata <= rdata_in;
        end
    end

endmodule

// ==== rtl/cache_top.sv ====
`timescale 1ns/10ps

module cache_top #(
    parameter int INDEX_BITS = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    output logic                      bvalid,
    input  logic                      bready,
    output logic [1:0]                bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic [31:0]               araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output cache_types_pkg::mem_req_t mem_req,
    input  cache_types_pkg::line_t    mem_rdata,
    input  logic                      mem_resp
);

    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;

    cpu_req_t         req;
    cpu_rsp_t         rsp;
    logic             req_start;
    way_ctrl_t [1:0]  way_ctrl;
    logic             load_lru;
    logic             lru_in;
    datamux_sel_t     datamux_sel;
    addrmux_sel_t     addrmux_sel;
    logic             hit;
    logic             hit_way;
    logic             lru_way;
    logic             lru_dirty;
    logic [31:0]      dp_rdata;
    logic             ctrl_done;
    logic [31:0]      mem_addr;
    line_t            mem_wdata;
    logic             mem_read;
    logic             mem_write;

    // Result and memory request bundles
    assign rsp     = '{rdata: dp_rdata, done: ctrl_done};
    assign mem_req = '{addr: mem_addr, wdata: mem_wdata, read: mem_read, write: mem_write};

    axil_cache_port i_port (
        .*,
        .done    (rsp.done),
        .rdata_in(rsp.rdata)
    );

    cache_control i_control (
        .*,
        .req_write(req.write),
        .done     (ctrl_done)
    );

    cache_datapath #(.INDEX_BITS(INDEX_BITS)) i_datapath (
        .*,
        .rdata(dp_rdata)
    );

endmodule

// ==== verification/line_mem_model.sv ====
`timescale 1ns/10ps

module line_mem_model (
    input  logic                      clk,
    input  logic                      rst,
    input  cache_types_pkg::mem_req_t mem_req,
    output cache_types_pkg::line_t    mem_rdata,
    output logic                      mem_resp
);

    import cache_types_pkg::*;

    localparam int LOG_DEPTH = 256;

    line_t       lines [logic [31:0]];
    logic [31:0] lfsr_state = 32'h82b6;
    logic        busy;
    logic [2:0]  delay;

    // Write-back log, read by the testbench
    int          wb_count = 0;
    logic [31:0] wb_addr [LOG_DEPTH];
    line_t       wb_data [LOG_DEPTH];

    // Odd multiplier, so every word address gets its own value
    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic line_t read_line(input logic [31:0] addr);
        line_t line;
        if (lines.exists(addr)) begin
            return lines[addr];
        end
        for (int w = 0; w < LINE_BYTES / 4; w++) begin
            line[w * 32 +: 32] = pattern_word(addr + 32'(4 * w));
        end
        return line;
    endfunction

    // Galois LFSR, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return value;
    endfunction

    initial begin
        mem_resp  = 1'b0;
        mem_rdata = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            delay     <= 3'd0;
            mem_resp  <= 1'b0;
            mem_rdata <= '0;
        end else begin
            mem_resp <= 1'b0;
            if (mem_resp) begin
                busy <= 1'b0;
            end else if (!busy && (mem_req.read || mem_req.write)) begin
                // New request draws a delay of 1 to 8 cycles
                busy  <= 1'b1;
                delay <= 3'(take_bits(3));
            end else if (busy && delay != 3'd0) begin
                delay <= delay - 3'd1;
            end else if (busy) begin
                mem_resp <= 1'b1;
                if (mem_req.write) begin
                    lines[mem_req.addr] = mem_req.wdata;
                    if (wb_count < LOG_DEPTH) begin
                        wb_addr[wb_count] = mem_req.addr;
                        wb_data[wb_count] = mem_req.wdata;
                    end
                    wb_count = wb_count + 1;
                end else begin
                    mem_rdata <= read_line(mem_req.addr);
                end
            end
        end
    end

endmodule

// ==== verification/tb_cache_top.sv ====
`timescale 1ns/10ps

module tb_cache_top;

    import cache_types_pkg::*;

    localparam int INDEX_BITS = 3;
    localparam int TAG_BITS   = 32 - INDEX_BITS - OFFSET_BITS;
    localparam int TIMEOUT    = 100;

    logic        clk = 1'b0;
    logic        rst;
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    mem_req_t    mem_req;
    line_t       mem_rdata;
    logic        mem_resp;

    logic        aw_done;
    logic        ar_done;
    logic        b_done;
    logic        r_done;
    logic [31:0] lfsr_state;
    logic [31:0] ref_mem [logic [31:0]];

    cache_top #(.INDEX_BITS(INDEX_BITS)) i_dut (.*);

    line_mem_model i_mem (.*);

    always #5 clk = ~clk;

    // Handshakes registered at the edge they happen on
    always @(posedge clk) begin
        if (rst) begin
            aw_done <= 1'b0;
            ar_done <= 1'b0;
            b_done  <= 1'b0;
            r_done  <= 1'b0;
        end else begin
            aw_done <= awvalid && awready && wvalid && wready;
            ar_done <= arvalid && arready;
            b_done  <= bvalid && bready;
            r_done  <= rvalid && rready;
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("Fail %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return value;
    endfunction

    // Initial memory contents with one value per word address
    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [31:0] word_addr;
        word_addr = {addr[31:2], 2'b00};
        if (ref_mem.exists(word_addr)) begin
            return ref_mem[word_addr];
        end
        return pattern_word(word_addr);
    endfunction

    function automatic void ref_write(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [3:0] strb);
        logic [31:0] word_addr;
        logic [31:0] word;
        word_addr = {addr[31:2], 2'b00};
        word      = ref_read(word_addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[b * 8 +: 8] = data[b * 8 +: 8];
            end
        end
        ref_mem[word_addr] = word;
    endfunction

    function automatic logic [31:0] make_addr(input logic [31:0] tag, input logic [31:0] set,
                                              input logic [31:0] word);
        return {tag[TAG_BITS-1:0], set[INDEX_BITS-1:0], word[OFFSET_BITS-3:0], 2'b00};
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] addr);
        return {addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    endfunction

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int cycles;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        cycles  = 0;
        @(negedge clk);
        while (!aw_done) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("Timeout waiting for the write address and data handshake");
            end
            @(negedge clk);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        cycles  = 0;
        while (!bvalid) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("Timeout waiting for the write response");
            end
            @(negedge clk);
        end
        check_value("bresp", 32'h0, 32'(bresp));
        cycles = 0;
        @(negedge clk);
        while (!b_done) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("Write response was never accepted");
            end
            @(negedge clk);
        end
        bready = 1'b0;
        ref_write(addr, data, strb);
    endtask

    // Optional hold of rready low to stall the read response
    task automatic axil_read(input logic [31:0] addr, input int hold_cycles,
                             output logic [31:0] data);
        int cycles;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold_cycles == 0);
        cycles  = 0;
        @(negedge clk);
        while (!ar_done) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("Timeout waiting for the read address handshake");
            end
            @(negedge clk);
        end
        arvalid = 1'b0;
        cycles  = 0;
        while (!rvalid) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("Timeout waiting for the read data");
            end
            @(negedge clk);
        end
        data = rdata;
        check_value("rresp", 32'h0, 32'(rresp));
        for (int i = 0; i < hold_cycles; i++) begin
            @(negedge clk);
            check_value("rvalid", 32'h1, 32'(rvalid));
            check_value("rdata", data, rdata);
            check_value("arready", 32'h0, 32'(arready));
        end
        rready = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!r_done) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("Read data was never accepted");
            end
            @(negedge clk);
        end
        rready = 1'b0;
    endtask

    task automatic read_and_compare(input logic [31:0] addr);
        logic [31:0] data;
        axil_read(addr, 0, data);
        check_value("rdata", ref_read(addr), data);
    endtask

    task automatic check_after_reset();
        logic [31:0] addr;
        logic [31:0] data;
        check_value("bvalid", 32'h0, 32'(bvalid));
        check_value("rvalid", 32'h0, 32'(rvalid));
        check_value("mem_req.read", 32'h0, 32'(mem_req.read));
        check_value("mem_req.write", 32'h0, 32'(mem_req.write));
        check_value("arready", 32'h0, 32'(arready));
        @(negedge clk);
        check_value("arready", 32'h1, 32'(arready));
        // Tag 0 equals the reset tag so only the clear valid bit forces the fill
        addr = make_addr(0, 0, 3);
        axil_read(addr, 0, data);
        check_value("rdata", pattern_word(addr), data);
    endtask

    task automatic write_then_read();
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
        addr     = make_addr(7, 1, 2);
        expected = pattern_word(addr);
        expected = {expected[31:24], 8'had, expected[15:8], 8'hef};
        axil_write(addr, 32'hdead_beef, 4'b0101);
        axil_read(addr, 0, data);
        check_value("rdata", expected, data);
        axil_read(addr + 32'h4, 0, data);
        check_value("rdata", pattern_word(addr + 32'h4), data);
    endtask

    task automatic dirty_eviction();
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        logic [31:0] addr_c;
        int          logged;
        addr_a = make_addr(10, 2, 1);
        addr_b = make_addr(11, 2, 1);
        addr_c = make_addr(12, 2, 1);
        logged = i_mem.wb_count;
        axil_write(addr_a, 32'h1111_2222, 4'hf);
        axil_write(addr_b, 32'h3333_4444, 4'b0011);
        axil_write(addr_c, 32'h5555_6666, 4'b1100);
        check_value("wb_count", 32'(logged + 1), 32'(i_mem.wb_count));
        check_value("wb_addr", line_of(addr_a), i_mem.wb_addr[logged]);
        for (int w = 0; w < LINE_BYTES / 4; w++) begin
            check_value("wb_data", ref_read(line_of(addr_a) + 32'(4 * w)),
                        i_mem.wb_data[logged][w * 32 +: 32]);
        end
        read_and_compare(addr_a);
    endtask

    task automatic lru_order();
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        logic [31:0] addr_c;
        int          logged;
        addr_a = make_addr(20, 3, 0);
        addr_b = make_addr(21, 3, 0);
        addr_c = make_addr(22, 3, 0);
        logged = i_mem.wb_count;
        // Dirty lines so the victim shows up in the write-back log
        axil_write(addr_a, 32'ha0a0_a0a0, 4'hf);
        axil_write(addr_b, 32'hb0b0_b0b0, 4'hf);
        read_and_compare(addr_a);
        read_and_compare(addr_c);
        check_value("wb_count", 32'(logged + 1), 32'(i_mem.wb_count));
        check_value("wb_addr", line_of(addr_b), i_mem.wb_addr[logged]);
        read_and_compare(addr_a);
        read_and_compare(addr_b);
    endtask

    task automatic back_pressure();
        logic [31:0] addr;
        logic [31:0] data;
        addr = make_addr(40, 0, 6);
        axil_read(addr, 6, data);
        check_value("rdata", ref_read(addr), data);
    endtask

    // Sets 4 to 7 with six tags keep evictions frequent
    task automatic random_traffic();
        logic [31:0] addr;
        logic [31:0] tag;
        logic [31:0] data;
        for (int n = 0; n < 200; n++) begin
            tag  = 32'd30 + take_bits(3) % 32'd6;
            addr = make_addr(tag, 32'd4 + take_bits(2), take_bits(3));
            if (take_bits(1) != 32'd0) begin
                data = take_bits(32);
                axil_write(addr, data, 4'(take_bits(4)));
            end else begin
                read_and_compare(addr);
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        bready     = 1'b0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        lfsr_state = 32'h82b6;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        check_after_reset();
        write_then_read();
        dirty_eviction();
        lru_order();
        back_pressure();
        random_traffic();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/cache_types_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/cache_array.sv
rtl/cache_datapath.sv
rtl/cache_control.sv
rtl/axil_cache_port.sv
rtl/cache_top.sv
verification/line_mem_model.sv
verification/tb_cache_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
    --top-module tb_cache_top -f compile.f -o sim_cache

output=$(./obj_dir/sim_cache 2>&1) || true
echo "$output"

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
